// File: source/sdram_pkg.sv
package sdram_pkg;

	// Data and address widths
	typedef logic [15:0] word_t;
	typedef logic [23:0] addr_t;

	// Address fields as placed on the SDRAM pins, bank above row above column
	typedef logic [1:0] bank_t;
	typedef logic [12:0] row_t;
	typedef logic [8:0] col_t;

	// Cache geometry, one word per line
	localparam int CACHE_INDEX_W = 4;
	localparam int CACHE_LINES = 2 ** CACHE_INDEX_W;
	typedef logic [CACHE_INDEX_W - 1:0] cache_index_t;
	typedef logic [23 - CACHE_INDEX_W:0] cache_tag_t;

	// SDRAM timing in clkSDRAM cycles
	localparam int CAS_LAT = 2;
	localparam int T_RCD = 3;
	localparam int T_RP = 3;
	localparam int T_RFC = 9;
	localparam int T_WR = 2;
	localparam int T_MRD = 2;

	// Burst length 1, sequential, CAS latency 2, single write
	localparam logic [12:0] MODE_WORD = 13'h220;

	// Command codes as {RAS_N, CAS_N, WE_N}
	typedef enum logic [2:0] {
		NOP = 3'b111,
		ACTIVE = 3'b011,
		READ = 3'b101,
		WRITE = 3'b100,
		PRECHARGE = 3'b010,
		REFRESH = 3'b001,
		LOAD_MODE = 3'b000
	} sdram_cmd_t;

endpackage

// File: source/mem_if.sv
`timescale 1ns/1ns

// Single word request/ready link
interface mem_if;

logic req;
logic we;
sdram_pkg::addr_t addr;
sdram_pkg::word_t wdata;
logic rdy;
sdram_pkg::word_t rdata;

// Holds req, we, addr and wdata until rdy
modport requester (
	output req, we, addr, wdata,
	input rdy, rdata
);

// rdy is a single cycle pulse, rdata valid with it on reads
modport responder (
	input req, we, addr, wdata,
	output rdy, rdata
);

endinterface

// File: source/sdram_arbiter.sv
`timescale 1ns/1ns

module sdram_arbiter (
	input logic clkSDRAM,
	input logic n_reset_in,
	mem_if.responder client_a,
	mem_if.responder client_b,
	mem_if.requester mem
);

logic busy, sel_q, last, pick, cur;

// Round robin when both ask, otherwise whoever asks
assign pick = (client_a.req && client_b.req) ? !last : client_b.req;

// Idle grants pass straight through so no cycle is lost
assign cur = busy ? sel_q : pick;

assign mem.req = cur ? client_b.req : client_a.req;
assign mem.we = cur ? client_b.we : client_a.we;
assign mem.addr = cur ? client_b.addr : client_a.addr;
assign mem.wdata = cur ? client_b.wdata : client_a.wdata;

// Only the granted client sees the response
assign client_a.rdy = mem.rdy && !cur;
assign client_b.rdy = mem.rdy && cur;
assign client_a.rdata = cur ? '0 : mem.rdata;
assign client_b.rdata = cur ? mem.rdata : '0;

always_ff @(posedge clkSDRAM, negedge n_reset_in) begin
	if (!n_reset_in) begin
		busy <= 1'b0;
		sel_q <= 1'b0;
		last <= 1'b0;
	end else if (mem.rdy) begin
		// Transfer done, release grant
		busy <= 1'b0;
		last <= cur;
	end else if (!busy && mem.req) begin
		busy <= 1'b1;
		sel_q <= pick;
	end
end

endmodule

// File: source/read_cache.sv
`timescale 1ns/1ns

module read_cache (
	input logic clkSDRAM,
	input logic n_reset_in,
	mem_if.responder up,
	mem_if.requester down
);

typedef enum logic [1:0] {
	IDLE,
	LOOKUP,
	FORWARD,
	RESPOND
} state_t;

state_t state;

// Line storage
logic [sdram_pkg::CACHE_LINES - 1:0] valid;
sdram_pkg::cache_tag_t tag_mem [sdram_pkg::CACHE_LINES];
sdram_pkg::word_t data_mem [sdram_pkg::CACHE_LINES];

sdram_pkg::cache_index_t index;
sdram_pkg::cache_tag_t tag;
sdram_pkg::word_t fill_word, rdata_q;
logic hit_q, fill;

assign {tag, index} = up.addr;

// Writes allocate with their own data, read misses with fetched data
assign fill = (state == FORWARD) && down.rdy;
assign fill_word = up.we ? up.wdata : down.rdata;

// Downstream request only while forwarding
assign down.req = (state == FORWARD);
assign down.we = up.we;
assign down.addr = up.addr;
assign down.wdata = up.wdata;

assign up.rdy = (state == LOOKUP && hit_q) || (state == RESPOND);
assign up.rdata = rdata_q;

always_ff @(posedge clkSDRAM, negedge n_reset_in) begin
	if (!n_reset_in) begin
		state <= IDLE;
		valid <= '0;
		hit_q <= 1'b0;
	end else begin
		case (state)
			IDLE: begin
				if (up.req) begin
					// Only reads can hit
					hit_q <= !up.we && valid[index] && (tag_mem[index] == tag);
					state <= LOOKUP;
				end
			end
			LOOKUP: begin
				state <= hit_q ? IDLE : FORWARD;
			end
			FORWARD: begin
				if (down.rdy) begin
					valid[index] <= 1'b1;
					state <= RESPOND;
				end
			end
			RESPOND: begin
				state <= IDLE;
			end
			default: begin
				state <= IDLE;
			end
		endcase
	end
end

// Tag and data arrays plus response word
always_ff @(posedge clkSDRAM) begin
	if (fill) begin
		tag_mem[index] <= tag;
		data_mem[index] <= fill_word;
	end
	if (state == IDLE && up.req)
		rdata_q <= data_mem[index];
	else if (fill)
		rdata_q <= fill_word;
end

endmodule

// File: source/sdram_ctrl.sv
`timescale 1ns/1ns

module sdram_ctrl #(
	parameter int t_init = 13200,
	parameter int t_refc = 1031
) (
	input logic clkSDRAM,
	input logic n_reset_in,
	mem_if.responder mem,
	output logic [12:0] dram_addr,
	output logic [1:0] dram_ba,
	output logic [1:0] dram_dqm,
	output logic dram_cke,
	output logic dram_cs_n,
	output logic dram_ras_n,
	output logic dram_cas_n,
	output logic dram_we_n,
	inout wire [15:0] dram_dq
);

typedef logic [$clog2(t_init + 1) - 1:0] wait_t;
typedef logic [$clog2(t_refc + 1) - 1:0] refc_t;

typedef enum logic [3:0] {
	INIT_WAIT,
	INIT_PRE,
	INIT_REF,
	INIT_MODE,
	IDLE,
	REFRESH,
	ACTIVATE,
	ACCESS,
	CAS_WAIT,
	RECOVER
} state_t;

state_t state;
wait_t wait_cnt;
refc_t ref_cnt;
logic ref_due, ref_second, op_we, rdy_q, dq_oe;
sdram_pkg::sdram_cmd_t cmd;
sdram_pkg::word_t dq_out, rdata_q;
sdram_pkg::bank_t bank;
sdram_pkg::row_t row;
sdram_pkg::col_t col;

assign {bank, row, col} = mem.addr;
assign {dram_ras_n, dram_cas_n, dram_we_n} = cmd;

// Drive DQ only during the WRITE command cycle
assign dram_dq = dq_oe ? dq_out : 'z;

assign mem.rdy = rdy_q;
assign mem.rdata = rdata_q;

// Refresh interval timer, free running
always_ff @(posedge clkSDRAM, negedge n_reset_in) begin
	if (!n_reset_in)
		ref_cnt <= refc_t'(t_refc - 1);
	else if (ref_cnt == '0)
		ref_cnt <= refc_t'(t_refc - 1);
	else
		ref_cnt <= ref_cnt - 1'b1;
end

always_ff @(posedge clkSDRAM, negedge n_reset_in) begin
	if (!n_reset_in) begin
		state <= INIT_WAIT;
		wait_cnt <= wait_t'(t_init - 1);
		cmd <= sdram_pkg::NOP;
		dram_cs_n <= 1'b1;
		dram_cke <= 1'b0;
		dram_addr <= '0;
		dram_ba <= '0;
		dram_dqm <= 2'b11;
		ref_due <= 1'b0;
		ref_second <= 1'b0;
		op_we <= 1'b0;
		rdy_q <= 1'b0;
		dq_oe <= 1'b0;
	end else begin
		cmd <= sdram_pkg::NOP;
		rdy_q <= 1'b0;
		dq_oe <= 1'b0;
		dram_cke <= 1'b1;
		dram_cs_n <= 1'b0;
		if (wait_cnt != '0) begin
			wait_cnt <= wait_cnt - 1'b1;
		end else begin
			case (state)
				INIT_WAIT: begin
					// Precharge all banks
					cmd <= sdram_pkg::PRECHARGE;
					dram_addr <= 13'h400;
					state <= INIT_PRE;
					wait_cnt <= wait_t'(sdram_pkg::T_RP - 1);
				end
				INIT_PRE: begin
					cmd <= sdram_pkg::REFRESH;
					ref_second <= 1'b1;
					state <= INIT_REF;
					wait_cnt <= wait_t'(sdram_pkg::T_RFC - 1);
				end
				INIT_REF: begin
					if (ref_second) begin
						cmd <= sdram_pkg::REFRESH;
						ref_second <= 1'b0;
						wait_cnt <= wait_t'(sdram_pkg::T_RFC - 1);
					end else begin
						cmd <= sdram_pkg::LOAD_MODE;
						dram_ba <= '0;
						dram_addr <= sdram_pkg::MODE_WORD;
						state <= INIT_MODE;
						wait_cnt <= wait_t'(sdram_pkg::T_MRD - 1);
					end
				end
				INIT_MODE: begin
					dram_dqm <= 2'b00;
					state <= IDLE;
				end
				IDLE: begin
					// Refresh wins; skip the request still held during its rdy cycle
					if (ref_due) begin
						cmd <= sdram_pkg::REFRESH;
						ref_due <= 1'b0;
						state <= REFRESH;
						wait_cnt <= wait_t'(sdram_pkg::T_RFC - 1);
					end else if (mem.req && !rdy_q) begin
						cmd <= sdram_pkg::ACTIVE;
						dram_ba <= bank;
						dram_addr <= row;
						op_we <= mem.we;
						state <= ACTIVATE;
						wait_cnt <= wait_t'(sdram_pkg::T_RCD - 2);
					end
				end
				REFRESH: begin
					state <= IDLE;
				end
				ACTIVATE: begin
					state <= ACCESS;
				end
				ACCESS: begin
					// Column with A10 set for auto precharge
					dram_addr <= {2'b00, 1'b1, 1'b0, col};
					if (op_we) begin
						cmd <= sdram_pkg::WRITE;
						dq_oe <= 1'b1;
						state <= RECOVER;
						wait_cnt <= wait_t'(sdram_pkg::T_WR + sdram_pkg::T_RP - 1);
					end else begin
						cmd <= sdram_pkg::READ;
						state <= CAS_WAIT;
						wait_cnt <= wait_t'(sdram_pkg::CAS_LAT);
					end
				end
				CAS_WAIT: begin
					// Data captured on this edge, answer right away
					rdy_q <= 1'b1;
					state <= RECOVER;
					wait_cnt <= wait_t'(sdram_pkg::T_RP - 1);
				end
				RECOVER: begin
					if (op_we)
						rdy_q <= 1'b1;
					state <= IDLE;
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
		if (ref_cnt == '0)
			ref_due <= 1'b1;
	end
end

// Write data and read capture
always_ff @(posedge clkSDRAM) begin
	if (state == ACCESS)
		dq_out <= mem.wdata;
	if (state == CAS_WAIT && wait_cnt == '0)
		rdata_q <= dram_dq;
end

endmodule

// File: source/sdram_system.sv
`timescale 1ns/1ns

module sdram_system #(
	parameter int t_init = 13200,
	parameter int t_refc = 1031
) (
	input logic clkSDRAM,
	input logic n_reset_in,

	// Client a
	input logic a_req,
	input logic a_we,
	input sdram_pkg::addr_t a_addr,
	input sdram_pkg::word_t a_wdata,
	output logic a_rdy,
	output sdram_pkg::word_t a_rdata,

	// Client b
	input logic b_req,
	input logic b_we,
	input sdram_pkg::addr_t b_addr,
	input sdram_pkg::word_t b_wdata,
	output logic b_rdy,
	output sdram_pkg::word_t b_rdata,

	// SDRAM pins
	output logic [12:0] dram_addr,
	output logic [1:0] dram_ba,
	output logic [1:0] dram_dqm,
	output logic dram_cke,
	output logic dram_cs_n,
	output logic dram_ras_n,
	output logic dram_cas_n,
	output logic dram_we_n,
	inout wire [15:0] dram_dq
);

mem_if client_if [2] ();
mem_if cache_if ();
mem_if dram_if ();

assign client_if[0].req = a_req;
assign client_if[0].we = a_we;
assign client_if[0].addr = a_addr;
assign client_if[0].wdata = a_wdata;
assign a_rdy = client_if[0].rdy;
assign a_rdata = client_if[0].rdata;

assign client_if[1].req = b_req;
assign client_if[1].we = b_we;
assign client_if[1].addr = b_addr;
assign client_if[1].wdata = b_wdata;
assign b_rdy = client_if[1].rdy;
assign b_rdata = client_if[1].rdata;

sdram_arbiter arb0 (.clkSDRAM, .n_reset_in,
	.client_a(client_if[0]), .client_b(client_if[1]), .mem(cache_if));

read_cache cache0 (.clkSDRAM, .n_reset_in, .up(cache_if), .down(dram_if));

sdram_ctrl #(.t_init(t_init), .t_refc(t_refc)) sdram0 (.clkSDRAM, .n_reset_in,
	.mem(dram_if), .dram_addr, .dram_ba, .dram_dqm, .dram_cke, .dram_cs_n,
	.dram_ras_n, .dram_cas_n, .dram_we_n, .dram_dq);

endmodule

// File: sim/tb_clock.sv
`timescale 1ns/1ns

module tb_clock (
	output logic clkSDRAM,
	output logic n_reset_in
);

initial begin
	clkSDRAM = 1'b0;
	n_reset_in = 1'b0;
	// Sixteen cycles of reset, released on a falling edge
	repeat (16) @(posedge clkSDRAM);
	@(negedge clkSDRAM);
	n_reset_in = 1'b1;
end

always #4 clkSDRAM = ~clkSDRAM;

endmodule

// File: sim/sdram_model.sv
`timescale 1ns/1ns

module sdram_model #(
	parameter int t_init = 13200,
	parameter int t_refc = 1031
) (
	input logic clkSDRAM,
	input logic n_reset_in,
	input logic [12:0] dram_addr,
	input logic [1:0] dram_ba,
	input logic [1:0] dram_dqm,
	input logic dram_cke,
	input logic dram_cs_n,
	input logic dram_ras_n,
	input logic dram_cas_n,
	input logic dram_we_n,
	inout wire [15:0] dram_dq,
	output logic init_done,
	output int act_count,
	output int ref_count,
	output int err_count
);

localparam int ref_gap_max = t_refc + sdram_pkg::T_RCD + sdram_pkg::CAS_LAT
	+ sdram_pkg::T_RP + sdram_pkg::T_WR + 4;

// Sparse storage keyed by bank, row and column
sdram_pkg::word_t store [sdram_pkg::addr_t];
sdram_pkg::row_t open_row [4];
sdram_pkg::sdram_cmd_t cmd;
sdram_pkg::addr_t key;
sdram_pkg::word_t rd_word, dq_val;
logic rd_pend, dq_oe;
int cyc, init_step, last_act, last_pre, last_ref, last_rd, last_wr;

assign dram_dq = dq_oe ? dq_val : 'z;
assign cmd = (dram_cke && !dram_cs_n) ?
	sdram_pkg::sdram_cmd_t'({dram_ras_n, dram_cas_n, dram_we_n}) : sdram_pkg::NOP;

// Unwritten words read back a pattern of the whole address
function automatic sdram_pkg::word_t fill_pattern(input sdram_pkg::addr_t a);
	return a[15:0] ^ {a[7:0], a[23:16]};
endfunction

task automatic fault(input string what);
	$display("Protocol error at %0t: %s", $time, what);
	err_count++;
endtask

always @(posedge clkSDRAM, negedge n_reset_in) begin
	if (!n_reset_in) begin
		cyc = 0;
		init_step = 0;
		last_act = -1000;
		last_pre = -1000;
		last_ref = -1000;
		last_rd = -1000;
		last_wr = -1000;
		err_count = 0;
		init_done <= 1'b0;
		act_count <= 0;
		ref_count <= 0;
		rd_pend <= 1'b0;
		dq_oe <= 1'b0;
	end else begin
		cyc++;
		// Read data goes out CAS_LAT edges after the READ
		dq_oe <= rd_pend;
		dq_val <= rd_word;
		rd_pend <= 1'b0;
		assert (dq_oe || cmd == sdram_pkg::WRITE || dram_dq === 16'hzzzz)
			else fault("DQ driven outside a WRITE");
		// Refresh interval plus the longest transfer
		assert (!init_done || cyc - last_ref != ref_gap_max + 1)
			else fault("gap between REFRESH commands too long");
		if (cmd != sdram_pkg::NOP) begin
			assert (cyc - last_pre >= sdram_pkg::T_RP)
				else fault("command inside tRP after PRECHARGE");
			assert (cyc - last_ref >= sdram_pkg::T_RFC)
				else fault("command inside tRFC after REFRESH");
			if (!init_done) begin
				assert (cyc > t_init)
					else fault("command before the power-up wait ended");
				case (init_step)
					0: assert (cmd == sdram_pkg::PRECHARGE && dram_addr[10])
						else fault("power-up did not start with PRECHARGE all");
					1, 2: assert (cmd == sdram_pkg::REFRESH)
						else fault("power-up is missing a REFRESH");
					default: assert (cmd == sdram_pkg::LOAD_MODE &&
							dram_addr == sdram_pkg::MODE_WORD)
						else fault("power-up did not end with the mode word");
				endcase
				init_step++;
				if (init_step == 4)
					init_done <= 1'b1;
			end
		end
		key = {dram_ba, open_row[dram_ba], dram_addr[8:0]};
		case (cmd)
			sdram_pkg::PRECHARGE: last_pre = cyc;
			sdram_pkg::REFRESH: begin
				last_ref = cyc;
				ref_count <= ref_count + 1;
			end
			sdram_pkg::ACTIVE: begin
				assert (cyc - last_rd >= sdram_pkg::CAS_LAT + sdram_pkg::T_RP &&
						cyc - last_wr >= sdram_pkg::T_WR + sdram_pkg::T_RP)
					else fault("ACTIVE before auto precharge finished");
				open_row[dram_ba] = dram_addr;
				last_act = cyc;
				act_count <= act_count + 1;
			end
			sdram_pkg::READ, sdram_pkg::WRITE: begin
				assert (cyc - last_act >= sdram_pkg::T_RCD)
					else fault("READ or WRITE inside tRCD");
				assert (dram_addr[10])
					else fault("READ or WRITE without auto precharge");
				if (cmd == sdram_pkg::WRITE) begin
					last_wr = cyc;
					if (dram_dqm == 2'b00)
						store[key] = dram_dq;
				end else begin
					last_rd = cyc;
					rd_pend <= 1'b1;
					rd_word <= store.exists(key) ? store[key] : fill_pattern(key);
				end
			end
			default: ;
		endcase
	end
end

endmodule

// File: sim/tb_sdram_system.sv
`timescale 1ns/1ns

module tb_sdram_system;

localparam int init_cycles = 200;
localparam int refresh_cycles = 300;
localparam int max_cycles = 16 + init_cycles + 64 * 40 + 400;

logic clkSDRAM, n_reset_in;
logic a_req, a_we, a_rdy, b_req, b_we, b_rdy;
sdram_pkg::addr_t a_addr, b_addr;
sdram_pkg::word_t a_wdata, a_rdata, b_wdata, b_rdata;
wire [12:0] dram_addr;
wire [1:0] dram_ba, dram_dqm;
wire dram_cke, dram_cs_n, dram_ras_n, dram_cas_n, dram_we_n;
wire [15:0] dram_dq;
logic init_done, fair_on;
logic [1:0] last_served;
logic [31:0] lfsr;
int act_count, ref_count, model_errors;
int errors, tests_passed, tests_failed, errors_at_start, cycles;
sdram_pkg::word_t shadow [sdram_pkg::addr_t];
sdram_pkg::addr_t used [$];

tb_clock clock0 (.clkSDRAM, .n_reset_in);

sdram_system #(.t_init(init_cycles), .t_refc(refresh_cycles)) UUT (.*);

sdram_model #(.t_init(init_cycles), .t_refc(refresh_cycles)) dram0 (.clkSDRAM, .n_reset_in,
	.dram_addr, .dram_ba, .dram_dqm, .dram_cke, .dram_cs_n, .dram_ras_n, .dram_cas_n,
	.dram_we_n, .dram_dq, .init_done, .act_count, .ref_count, .err_count(model_errors));

// Taps 32, 22, 2, 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

task automatic take_bits(input int n, output logic [31:0] bits);
	bits = '0;
	for (int i = 0; i < n; i++) begin
		lfsr = lfsr_next(lfsr);
		bits = {bits[30:0], lfsr[0]};
	end
endtask

task automatic drive_client(input logic cl, input logic req, input logic we,
		input sdram_pkg::addr_t addr, input sdram_pkg::word_t wdata);
	if (cl) begin
		b_req = req;
		b_we = we;
		b_addr = addr;
		b_wdata = wdata;
	end else begin
		a_req = req;
		a_we = we;
		a_addr = addr;
		a_wdata = wdata;
	end
endtask

// One handshake; with hold set req stays up for a following transfer
task automatic transfer(input logic cl, input logic we, input sdram_pkg::addr_t addr,
		input sdram_pkg::word_t wdata, input logic hold, output sdram_pkg::word_t rdata,
		output int waited);
	logic seen;
	waited = 0;
	seen = 1'b0;
	@(negedge clkSDRAM);
	drive_client(cl, 1'b1, we, addr, wdata);
	while (!seen) begin
		@(negedge clkSDRAM);
		waited++;
		seen = cl ? b_rdy : a_rdy;
	end
	rdata = cl ? b_rdata : a_rdata;
	if (we)
		shadow[addr] = wdata;
	if (!hold) begin
		@(negedge clkSDRAM);
		drive_client(cl, 1'b0, we, addr, wdata);
	end
endtask

task automatic write_word(input logic cl, input sdram_pkg::addr_t addr,
		input sdram_pkg::word_t data);
	sdram_pkg::word_t unused;
	int waited;
	transfer(cl, 1'b1, addr, data, 1'b0, unused, waited);
endtask

task automatic read_check(input logic cl, input sdram_pkg::addr_t addr, input logic hold,
		output int waited);
	sdram_pkg::word_t got;
	transfer(cl, 1'b0, addr, '0, hold, got, waited);
	assert (got === shadow[addr]) else begin
		$display("Mismatch at %0t: %s expected %h got %h", $time,
			cl ? "b_rdata" : "a_rdata", shadow[addr], got);
		errors++;
	end
endtask

task automatic expect_count(input string what, input int exp, input int got);
	assert (exp == got) else begin
		$display("Mismatch at %0t: %s expected %0d got %0d", $time, what, exp, got);
		errors++;
	end
endtask

task automatic finish_test(input string name);
	if (errors + model_errors == errors_at_start) begin
		tests_passed++;
		$display("Test %s: ok", name);
	end else begin
		tests_failed++;
		$display("Test %s: %0d errors", name, errors + model_errors - errors_at_start);
	end
	errors_at_start = errors + model_errors;
endtask

assert property (@(posedge clkSDRAM) disable iff (!n_reset_in) a_rdy |-> a_req)
	else begin
		$display("Client a got rdy with req low at %0t", $time);
		errors++;
	end
assert property (@(posedge clkSDRAM) disable iff (!n_reset_in) b_rdy |-> b_req)
	else begin
		$display("Client b got rdy with req low at %0t", $time);
		errors++;
	end
assert property (@(posedge clkSDRAM) disable iff (!n_reset_in) (a_rdy || b_rdy) |-> init_done)
	else begin
		$display("A client got rdy before SDRAM power-up finished at %0t", $time);
		errors++;
	end
assert property (@(posedge clkSDRAM) disable iff (!n_reset_in)
		(fair_on && a_rdy) |-> last_served != 2'd0)
	else begin
		$display("Client a served twice in a row at %0t", $time);
		errors++;
	end
assert property (@(posedge clkSDRAM) disable iff (!n_reset_in)
		(fair_on && b_rdy) |-> last_served != 2'd1)
	else begin
		$display("Client b served twice in a row at %0t", $time);
		errors++;
	end

always @(posedge clkSDRAM) begin
	if (fair_on && a_rdy)
		last_served <= 2'd0;
	else if (fair_on && b_rdy)
		last_served <= 2'd1;
end

always @(posedge clkSDRAM) begin
	cycles++;
	if (cycles > max_cycles) begin
		$display("Run stopped after %0d cycles with transfers still open", cycles);
		$display("TEST FAILED");
		$finish;
	end
end

initial begin
	sdram_pkg::addr_t addr, addr2;
	logic [31:0] r;
	int waited, act0;
	drive_client(1'b0, 1'b0, 1'b0, '0, '0);
	drive_client(1'b1, 1'b0, 1'b0, '0, '0);
	lfsr = 32'hda9d;
	{errors, tests_passed, tests_failed, errors_at_start, cycles} = '0;
	fair_on = 1'b0;
	last_served = 2'd2;
	@(posedge n_reset_in);

	// Request right away, it must wait for power-up
	take_bits(24, r);
	addr = r[23:0];
	take_bits(16, r);
	write_word(1'b0, addr, r[15:0]);
	used.push_back(addr);
	finish_test("power-up order");

	repeat (11) begin
		take_bits(24, r);
		addr = r[23:0];
		take_bits(16, r);
		write_word(1'b0, addr, r[15:0]);
		used.push_back(addr);
	end
	foreach (used[i])
		read_check(1'b1, used[i], 1'b0, waited);
	finish_test("write then read");

	for (int i = 0; i < 4; i++) begin
		read_check(1'b0, used[i], 1'b0, waited);
		act0 = act_count;
		read_check(1'b1, used[i], 1'b0, waited);
		expect_count("b_rdy latency", 1, waited);
		expect_count("act_count on a hit", act0, act_count);
	end
	finish_test("cache hit");

	// Same index, tag differs in its lowest bit
	take_bits(24, r);
	addr = r[23:0];
	addr2 = addr ^ (24'd1 << sdram_pkg::CACHE_INDEX_W);
	act0 = act_count;
	take_bits(16, r);
	write_word(1'b0, addr, r[15:0]);
	take_bits(16, r);
	write_word(1'b1, addr2, r[15:0]);
	read_check(1'b0, addr, 1'b0, waited);
	read_check(1'b1, addr2, 1'b0, waited);
	expect_count("act_count after evictions", act0 + 4, act_count);
	read_check(1'b0, addr2, 1'b0, waited);
	expect_count("act_count after re-read", act0 + 4, act_count);
	finish_test("eviction");

	fair_on = 1'b1;
	fork
		begin
			int wa;
			for (int i = 0; i < 8; i++)
				read_check(1'b0, used[i], i < 7, wa);
		end
		begin
			int wb;
			for (int i = 0; i < 8; i++)
				read_check(1'b1, used[11 - i], i < 7, wb);
		end
	join
	fair_on = 1'b0;
	finish_test("fair arbitration");

	repeat (5) begin
		take_bits(24, r);
		addr = r[23:0];
		take_bits(16, r);
		write_word(1'b0, addr, r[15:0]);
		read_check(1'b1, addr, 1'b0, waited);
	end
	assert (ref_count > 2) else begin
		$display("No periodic REFRESH seen after power-up");
		errors++;
	end
	finish_test("refresh");

	$display("Tests passed: %0d, failed: %0d, errors: %0d", tests_passed, tests_failed,
		errors + model_errors);
	if (tests_failed == 0 && errors + model_errors == 0)
		$display("TEST PASSED");
	else
		$display("TEST FAILED");
	$finish;
end

endmodule

// File: sdram_system.f
source/sdram_pkg.sv
source/mem_if.sv
source/sdram_arbiter.sv
source/read_cache.sv
source/sdram_ctrl.sv
source/sdram_system.sv
sim/tb_clock.sv
sim/sdram_model.sv
sim/tb_sdram_system.sv
